// ==== filelist.f ====
+incdir+.
saa_reg_pkg.sv
saa_audio_pkg.sv
saa_reg_decode.sv
saa_tone_gen.sv
saa_channel_mix.sv
saa_sound_top.sv
saa_sound_checker.sv
tb_saa_sound.sv

// ==== Bender.yml ====
package:
  name: saa_sound

sources:
  - include_dirs:
      - .
    files:
      - saa_reg_pkg.sv
      - saa_audio_pkg.sv
      - saa_reg_decode.sv
      - saa_tone_gen.sv
      - saa_channel_mix.sv
      - saa_sound_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - saa_sound_checker.sv
      - tb_saa_sound.sv

// ==== tb_saa_sound.sv ====
`timescale 1ns/10ps

`include "saa_macros.svh"

module tb_saa_sound;

	logic                   clk_sys;
	logic                   rst;
	logic                   ce;
	logic                   bus_wr;
	logic                   bus_a0;
	logic [`SAA_BUS_W-1:0]  bus_din;
	saa_audio_pkg::mix_t    out_l;
	saa_audio_pkg::mix_t    out_r;

	logic [31:0] lfsr;
	int          err_timeout;
	int          err_other;
	bit          aborted;      // Set when a wait runs out
	int          n_checks;
	int          n_nonzero;
	int          err_l;
	int          err_r;

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	saa_sound_top u_saa_sound_top (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce      (ce),
		.bus_wr  (bus_wr),
		.bus_a0  (bus_a0),
		.bus_din (bus_din),
		.out_l   (out_l),
		.out_r   (out_r)
	);

	saa_sound_checker u_checker (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ce        (ce),
		.bus_wr    (bus_wr),
		.bus_a0    (bus_a0),
		.bus_din   (bus_din),
		.out_l     (out_l),
		.out_r     (out_r),
		.n_checks  (n_checks),
		.n_nonzero (n_nonzero),
		.err_l     (err_l),
		.err_r     (err_r)
	);

	////////////////////////////////////////////////////////////
	// Random source and bus driving
	////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int nbits, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic drive_cycle(input logic wr, input logic a0, input logic [7:0] din);
		logic [31:0] r;
		@(posedge clk_sys);
		#10;
		draw_bits(2, r);
		ce      = |r[1:0];  // High on about three cycles in four
		bus_wr  = wr;
		bus_a0  = a0;
		bus_din = din;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle(1'b0, 1'b0, 8'h00);
	endtask

	task automatic host_write(input logic with_addr, input logic [7:0] abyte,
			input logic [7:0] data);
		if (with_addr)
			drive_cycle(1'b1, 1'b1, abyte);
		drive_cycle(1'b1, 1'b0, data);
		idle_cycles(1);
	endtask

	function automatic bit outputs_nonzero();
		return (out_l != 0) || (out_r != 0);
	endfunction

	task automatic wait_outputs(input bit want_nonzero, input int limit, input string what);
		int n;
		n = 0;
		while (outputs_nonzero() != want_nonzero && n < limit) begin
			idle_cycles(1);
			n++;
		end
		if (outputs_nonzero() != want_nonzero) begin
			$display("Timeout after %0d cycles while waiting for %s", limit, what);
			err_timeout++;
			aborted = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test phases
	////////////////////////////////////////////////////////////

	task automatic mute_phase();
		host_write(1'b0, 8'h00, 8'h3c);   // No address yet, lands in amplitude 0
		host_write(1'b1, 8'h08, 8'hff);   // Channel 0 frequency byte 255
		host_write(1'b1, 8'h10, 8'h07);   // Channel 0 octave 7
		host_write(1'b1, 8'h14, 8'h01);
		host_write(1'b1, 8'h0f, 8'h55);   // Unlisted address
		idle_cycles(1500);                // Tone runs, sound still off
	endtask

	task automatic single_tone_phase();
		host_write(1'b1, 8'h1c, 8'h01);
		wait_outputs(1'b1, 2000, "channel 0 to go high");
		if (!aborted) wait_outputs(1'b0, 2000, "channel 0 to go low");
		if (!aborted) wait_outputs(1'b1, 2000, "channel 0 to go high again");
	endtask

	task automatic tone_hold_phase();
		host_write(1'b1, 8'h1c, 8'h03);
		wait_outputs(1'b0, 10, "the tone reset to silence the outputs");
		idle_cycles(200);
		host_write(1'b1, 8'h1c, 8'h01);
		if (!aborted) wait_outputs(1'b1, 2000, "channel 0 to restart after tone reset");
	endtask

	task automatic random_phase();
		logic [31:0] r;
		logic [31:0] sel;
		logic [4:0]  addr;
		logic [7:0]  data;
		logic        with_addr;
		for (int i = 0; i < 160; i++) begin
			draw_bits(3, sel);
			draw_bits(3, r);
			case (sel[2:0])
				3'd0, 3'd5: addr = 5'(`SAA_ADDR_AMP0 + r % `SAA_NUM_CH);
				3'd1, 3'd6: addr = 5'(`SAA_ADDR_FREQ0 + r % `SAA_NUM_CH);
				3'd2:       addr = 5'(`SAA_ADDR_OCT0 + r % (`SAA_NUM_CH / 2));
				3'd3:       addr = `SAA_ADDR_FREQEN;
				3'd4:       addr = `SAA_ADDR_CTRL;
				default: begin
					draw_bits(5, r);
					addr = r[4:0];    // Any address, mostly unlisted
				end
			endcase
			draw_bits(8, r);
			data = r[7:0];
			if (addr >= `SAA_ADDR_FREQ0 && addr < `SAA_ADDR_FREQ0 + `SAA_NUM_CH)
				data = data | 8'hf8;      // Near 255 for short periods
			else if (addr >= `SAA_ADDR_OCT0 && addr < `SAA_ADDR_OCT0 + `SAA_NUM_CH / 2)
				data = data | 8'h44;      // Octaves 4 to 7
			else if (addr == `SAA_ADDR_CTRL) begin
				draw_bits(3, r);
				data[0] = (r[2:0] != 3'd0);
				draw_bits(3, r);
				data[1] = (r[2:0] == 3'd0);  // Tone reset is rare
			end
			draw_bits(3, r);
			with_addr = (r[2:0] != 3'd0);
			draw_bits(3, r);
			host_write(with_addr, {r[2:0], addr}, data);
			draw_bits(8, r);
			idle_cycles(int'(r[7:0]));
		end
	endtask

	initial begin
		rst         = 1'b1;
		ce          = 1'b0;
		bus_wr      = 1'b0;
		bus_a0      = 1'b0;
		bus_din     = '0;
		lfsr        = 32'hb6aa90f3;
		err_timeout = 0;
		err_other   = 0;
		aborted     = 1'b0;

		repeat (3) @(posedge clk_sys);
		#10;
		rst = 1'b0;

		mute_phase();
		if (!aborted) single_tone_phase();
		if (!aborted) tone_hold_phase();
		if (!aborted) random_phase();
		idle_cycles(20);

		if (n_nonzero == 0) begin
			$display("No nonzero output was expected during the run");
			err_other++;
		end
		$display("Compares %0d, nonzero %0d, out_l errors %0d, out_r errors %0d,%s",
			n_checks, n_nonzero, err_l, err_r,
			$sformatf(" timeouts %0d, other %0d", err_timeout, err_other));
		if (err_l + err_r + err_timeout + err_other == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== saa_sound_checker.sv ====
`timescale 1ns/10ps

`include "saa_macros.svh"

module saa_sound_checker (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   ce,
	input  logic                   bus_wr,
	input  logic                   bus_a0,
	input  logic [`SAA_BUS_W-1:0]  bus_din,
	input  saa_audio_pkg::mix_t    out_l,
	input  saa_audio_pkg::mix_t    out_r,
	output int                     n_checks,   // Compares made
	output int                     n_nonzero,  // Compares with a nonzero expectation
	output int                     err_l,
	output int                     err_r
);

	saa_reg_pkg::reg_addr_t   m_addr;
	saa_reg_pkg::amp_vec_t    m_amp;
	saa_reg_pkg::freq_vec_t   m_freq;
	saa_reg_pkg::octave_vec_t m_oct;
	logic [`SAA_NUM_CH-1:0]   m_fen;
	logic                     m_snd;
	logic                     m_trst;

	logic [`SAA_PRESC_W-1:0]  m_presc [`SAA_NUM_CH];  // Wraps over 8 bits
	saa_reg_pkg::freq_t       m_fcnt  [`SAA_NUM_CH];  // Wraps over 9 bits
	logic [`SAA_NUM_CH-1:0]   m_tone;

	saa_audio_pkg::mix_t      exp_l;  // Model of the output register
	saa_audio_pkg::mix_t      exp_r;
	logic                     primed; // Outputs are defined once reset was seen

	initial begin
		n_checks  = 0;
		n_nonzero = 0;
		err_l     = 0;
		err_r     = 0;
		primed    = 1'b0;
	end

	// ce pulses per frequency counter step
	function automatic int presc_period(input saa_reg_pkg::octave_t oct);
		return 256 >> oct;
	endfunction

	task automatic model_clear();
		m_addr = '0;
		m_amp  = '0;
		m_freq = '0;
		m_oct  = '0;
		m_fen  = '0;
		m_snd  = 1'b0;
		m_trst = 1'b0;
		m_tone = '0;
		exp_l  = '0;
		exp_r  = '0;
		for (int ch = 0; ch < `SAA_NUM_CH; ch++) begin
			m_presc[ch] = '0;
			m_fcnt[ch]  = '0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	task automatic model_write(input saa_reg_pkg::reg_addr_t a, input logic [7:0] d);
		int ai;
		ai = int'(a);
		if (ai >= `SAA_ADDR_AMP0 && ai < `SAA_ADDR_AMP0 + `SAA_NUM_CH) begin
			m_amp[ai - `SAA_ADDR_AMP0].left  = d[3:0];
			m_amp[ai - `SAA_ADDR_AMP0].right = d[7:4];
		end else if (ai >= `SAA_ADDR_FREQ0 && ai < `SAA_ADDR_FREQ0 + `SAA_NUM_CH) begin
			m_freq[ai - `SAA_ADDR_FREQ0] = saa_reg_pkg::freq_t'(`SAA_FREQ_BIAS - int'(d));
		end else if (ai >= `SAA_ADDR_OCT0 && ai < `SAA_ADDR_OCT0 + `SAA_NUM_CH / 2) begin
			m_oct[2 * (ai - `SAA_ADDR_OCT0)]     = d[2:0];
			m_oct[2 * (ai - `SAA_ADDR_OCT0) + 1] = d[6:4];
		end else if (ai == `SAA_ADDR_FREQEN) begin
			m_fen = d[`SAA_NUM_CH-1:0];
		end else if (ai == `SAA_ADDR_CTRL) begin
			m_snd  = d[0];
			m_trst = d[1];
		end
	endtask

	task automatic model_tones();
		for (int ch = 0; ch < `SAA_NUM_CH; ch++) begin
			if (m_trst) begin
				m_presc[ch] = '0;
				m_fcnt[ch]  = '0;
				m_tone[ch]  = 1'b0;
			end else if (ce) begin
				if (m_presc[ch] == presc_period(m_oct[ch]) - 1) begin
					m_presc[ch] = '0;
					if (m_fcnt[ch] == m_freq[ch]) begin
						m_fcnt[ch] = '0;
						m_tone[ch] = ~m_tone[ch];  // End of a half period
					end else begin
						m_fcnt[ch] = m_fcnt[ch] + 1'b1;
					end
				end else begin
					m_presc[ch] = m_presc[ch] + 1'b1;
				end
			end
		end
	endtask

	task automatic model_mix();
		int sl;
		int sr;
		sl = 0;
		sr = 0;
		for (int ch = 0; ch < `SAA_NUM_CH; ch++) begin
			if (m_tone[ch] && m_fen[ch]) begin
				sl = sl + int'(m_amp[ch].left);
				sr = sr + int'(m_amp[ch].right);
			end
		end
		exp_l = m_snd ? saa_audio_pkg::mix_t'(sl) : '0;
		exp_r = m_snd ? saa_audio_pkg::mix_t'(sr) : '0;
	endtask

	////////////////////////////////////////////////////////////
	// Compare, then advance the model one edge
	////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		if (primed) begin
			n_checks = n_checks + 1;
			if (exp_l != 0 || exp_r != 0)
				n_nonzero = n_nonzero + 1;
			if (out_l !== exp_l) begin
				$display("Error at %0d ns: out_l expected %0d, actual %0d",
					$time, exp_l, out_l);
				err_l = err_l + 1;
			end
			if (out_r !== exp_r) begin
				$display("Error at %0d ns: out_r expected %0d, actual %0d",
					$time, exp_r, out_r);
				err_r = err_r + 1;
			end
		end
		if (rst) begin
			model_clear();
			primed = 1'b1;
		end else begin
			model_mix();    // Uses the tones and registers from before the edge
			model_tones();
			if (bus_wr && bus_a0)
				m_addr = bus_din[`SAA_ADDR_W-1:0];
			else if (bus_wr)
				model_write(m_addr, bus_din);
		end
	end

endmodule

// ==== saa_sound_top.sv ====
`timescale 1ns/10ps

`include "saa_macros.svh"

module saa_sound_top (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   ce,       // Tone clock enable
	input  logic                   bus_wr,
	input  logic                   bus_a0,
	input  logic [`SAA_BUS_W-1:0]  bus_din,
	output saa_audio_pkg::mix_t    out_l,
	output saa_audio_pkg::mix_t    out_r
);

	saa_reg_pkg::freq_vec_t   freq_vec;
	saa_reg_pkg::octave_vec_t octave_vec;
	saa_reg_pkg::amp_vec_t    amp_vec;

	logic [`SAA_NUM_CH-1:0] freq_en;
	logic [`SAA_NUM_CH-1:0] tone;
	logic                   sound_en;
	logic                   tone_rst;

	////////////////////////////////////////////////////////////
	// Host registers
	////////////////////////////////////////////////////////////

	saa_reg_decode u_reg_decode (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.bus_wr     (bus_wr),
		.bus_a0     (bus_a0),
		.bus_din    (bus_din),
		.freq_vec   (freq_vec),
		.octave_vec (octave_vec),
		.amp_vec    (amp_vec),
		.freq_en    (freq_en),
		.sound_en   (sound_en),
		.tone_rst   (tone_rst)
	);

	// One square-wave generator per channel
	for (genvar ch = 0; ch < `SAA_NUM_CH; ch++) begin : g_tone
		saa_tone_gen u_tone_gen (
			.clk_sys  (clk_sys),
			.rst      (rst),
			.ce       (ce),
			.tone_rst (tone_rst),
			.freq     (freq_vec[ch]),
			.octave   (octave_vec[ch]),
			.tone     (tone[ch])
		);
	end

	saa_channel_mix u_channel_mix (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.tone     (tone),
		.freq_en  (freq_en),
		.amp_vec  (amp_vec),
		.sound_en (sound_en),
		.out_l    (out_l),
		.out_r    (out_r)
	);

endmodule

// ==== saa_channel_mix.sv ====
`timescale 1ns/10ps

`include "saa_macros.svh"

module saa_channel_mix (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic [`SAA_NUM_CH-1:0]  tone,
	input  logic [`SAA_NUM_CH-1:0]  freq_en,
	input  saa_reg_pkg::amp_vec_t   amp_vec,
	input  logic                    sound_en,
	output saa_audio_pkg::mix_t     out_l,
	output saa_audio_pkg::mix_t     out_r
);

	logic [`SAA_NUM_CH-1:0] active;  // Tone high and channel enabled

	saa_audio_pkg::level_t lvl_l [`SAA_NUM_CH];
	saa_audio_pkg::level_t lvl_r [`SAA_NUM_CH];

	saa_audio_pkg::mix_t sum_l;
	saa_audio_pkg::mix_t sum_r;

	assign active = tone & freq_en;

	////////////////////////////////////////////////////////////
	// Amplitude gating per channel
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int ch = 0; ch < `SAA_NUM_CH; ch++) begin
			lvl_l[ch] = active[ch] ? amp_vec[ch].left  : '0;
			lvl_r[ch] = active[ch] ? amp_vec[ch].right : '0;
		end
	end

	// Stereo sum, no compression
	always_comb begin
		sum_l = '0;
		sum_r = '0;
		for (int ch = 0; ch < `SAA_NUM_CH; ch++) begin
			sum_l = sum_l + saa_audio_pkg::mix_t'(lvl_l[ch]);
			sum_r = sum_r + saa_audio_pkg::mix_t'(lvl_r[ch]);
		end
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			out_l <= '0;
			out_r <= '0;
		end else if (sound_en) begin
			out_l <= sum_l;
			out_r <= sum_r;
		end else begin
			out_l <= '0;  // Global mute
			out_r <= '0;
		end
	end

endmodule

// ==== saa_tone_gen.sv ====
`timescale 1ns/10ps

`include "saa_macros.svh"

module saa_tone_gen (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  ce,        // Advance on these cycles only
	input  logic                  tone_rst,  // Control bit 1
	input  saa_reg_pkg::freq_t    freq,
	input  saa_reg_pkg::octave_t  octave,
	output logic                  tone
);

	logic [`SAA_PRESC_W-1:0] presc;      // Octave prescaler
	logic [`SAA_PRESC_W-1:0] presc_lim;  // 255 at octave 0, 1 at octave 7
	saa_reg_pkg::freq_t      fcnt;       // Frequency counter

	logic presc_wrap;
	logic fcnt_wrap;

	// Each octave step halves the prescaler period
	assign presc_lim  = {`SAA_PRESC_W{1'b1}} >> octave;
	assign presc_wrap = (presc == presc_lim);
	assign fcnt_wrap  = (fcnt == freq);

	////////////////////////////////////////////////////////////
	// Prescaler, frequency counter and square wave
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst || tone_rst) begin
			presc <= '0;
			fcnt  <= '0;
			tone  <= 1'b0;
		end else if (ce) begin
			if (presc_wrap) begin
				presc <= '0;
				if (fcnt_wrap) begin
					fcnt <= '0;
					tone <= ~tone;  // Half period complete
				end else begin
					fcnt <= fcnt + 1'b1;
				end
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

	// A compare value lowered below the running count rolls over the
	// full 9-bit range before the next toggle, as on the chip

endmodule

// ==== saa_reg_decode.sv ====
`timescale 1ns/10ps

`include "saa_macros.svh"

module saa_reg_decode (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      bus_wr,      // One cycle per host write
	input  logic                      bus_a0,      // 1 = address, 0 = data
	input  logic [`SAA_BUS_W-1:0]     bus_din,
	output saa_reg_pkg::freq_vec_t    freq_vec,
	output saa_reg_pkg::octave_vec_t  octave_vec,
	output saa_reg_pkg::amp_vec_t     amp_vec,
	output logic [`SAA_NUM_CH-1:0]    freq_en,
	output logic                      sound_en,
	output logic                      tone_rst
);

	saa_reg_pkg::reg_addr_t addr;  // Target of the next data write

	logic wr_addr;
	logic wr_data;

	assign wr_addr = bus_wr & bus_a0;
	assign wr_data = bus_wr & ~bus_a0;

	////////////////////////////////////////////////////////////
	// Address latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			addr <= '0;  // Data writes before any address go to amplitude 0
		end else if (wr_addr) begin
			addr <= bus_din[`SAA_ADDR_W-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			amp_vec    <= '0;
			freq_vec   <= '0;
			octave_vec <= '0;
			freq_en    <= '0;
			sound_en   <= 1'b0;
			tone_rst   <= 1'b0;
		end else if (wr_data) begin
			for (int ch = 0; ch < `SAA_NUM_CH; ch++) begin
				// Amplitude, low nibble left
				if (addr == saa_reg_pkg::reg_addr_t'(`SAA_ADDR_AMP0 + ch)) begin
					amp_vec[ch].left  <= bus_din[`SAA_AMP_W-1:0];
					amp_vec[ch].right <= bus_din[2*`SAA_AMP_W-1:`SAA_AMP_W];
				end
				// Counter compare value, higher byte gives a higher pitch
				if (addr == saa_reg_pkg::reg_addr_t'(`SAA_ADDR_FREQ0 + ch)) begin
					freq_vec[ch] <= saa_reg_pkg::freq_t'(`SAA_FREQ_BIAS)
						- saa_reg_pkg::freq_t'(bus_din);
				end
			end

			// One byte carries an even/odd channel pair
			for (int pr = 0; pr < `SAA_NUM_CH / 2; pr++) begin
				if (addr == saa_reg_pkg::reg_addr_t'(`SAA_ADDR_OCT0 + pr)) begin
					octave_vec[2*pr]   <= bus_din[`SAA_OCT_W-1:0];
					octave_vec[2*pr+1] <= bus_din[4+`SAA_OCT_W-1:4];
				end
			end

			if (addr == `SAA_ADDR_FREQEN)
				freq_en <= bus_din[`SAA_NUM_CH-1:0];

			if (addr == `SAA_ADDR_CTRL) begin
				sound_en <= bus_din[0];
				tone_rst <= bus_din[1];  // Holds every tone generator cleared
			end
			// Anything else in the map is ignored
		end
	end

endmodule

// ==== saa_audio_pkg.sv ====
`include "saa_macros.svh"

package saa_audio_pkg;

	////////////////////////////////////////////////////////////
	// Audio path types
	////////////////////////////////////////////////////////////

	// One channel's contribution to one side, after gating
	typedef logic [`SAA_AMP_W-1:0] level_t;

	// Sum of all six channel levels on one side, 6 x 15 fits in 7 bits
	typedef logic [`SAA_MIX_W-1:0] mix_t;

endpackage

// ==== saa_reg_pkg.sv ====
`include "saa_macros.svh"

package saa_reg_pkg;

	////////////////////////////////////////////////////////////
	// Scalar register fields
	////////////////////////////////////////////////////////////

	typedef logic [`SAA_ADDR_W-1:0] reg_addr_t;  // Latched by an a0 write
	typedef logic [`SAA_FREQ_W-1:0] freq_t;      // Bias minus the written byte
	typedef logic [`SAA_OCT_W-1:0]  octave_t;

	// Right in the upper nibble, as the byte arrives from the host
	typedef struct packed {
		logic [`SAA_AMP_W-1:0] right;
		logic [`SAA_AMP_W-1:0] left;
	} amp_pair_t;

	////////////////////////////////////////////////////////////
	// Per-channel register banks
	////////////////////////////////////////////////////////////

	typedef freq_t     [`SAA_NUM_CH-1:0] freq_vec_t;
	typedef octave_t   [`SAA_NUM_CH-1:0] octave_vec_t;
	typedef amp_pair_t [`SAA_NUM_CH-1:0] amp_vec_t;  // Index is the channel number

endpackage

// ==== saa_macros.svh ====
`ifndef SAA_MACROS_SVH
`define SAA_MACROS_SVH

////////////////////////////////////////////////////////////
// Channel and bus geometry
////////////////////////////////////////////////////////////

`define SAA_NUM_CH     6    // Tone channels
`define SAA_BUS_W      8    // Host data bus
`define SAA_ADDR_W     5    // Register address field of the bus byte

`define SAA_AMP_W      4    // One side of an amplitude register
`define SAA_FREQ_W     9    // Frequency compare value and counter
`define SAA_FREQ_BIAS  510  // Stored frequency is this minus the byte
`define SAA_OCT_W      3    // Octave number
`define SAA_PRESC_W    8    // Octave prescaler, full count at octave 0
`define SAA_MIX_W      7    // Sum of six 4-bit levels

////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////

`define SAA_ADDR_AMP0   5'h00  // Amplitude 0..5
`define SAA_ADDR_FREQ0  5'h08  // Frequency 0..5
`define SAA_ADDR_OCT0   5'h10  // Octave pairs 1:0, 3:2, 5:4
`define SAA_ADDR_FREQEN 5'h14  // Frequency enable, one bit per channel
`define SAA_ADDR_CTRL   5'h1C  // Bit 0 sound enable, bit 1 tone reset

`endif
